// ==== include/l2_defs.svh ====
// L2 cache bank geometry
// Word, address and block widths, set and way counts, plus the
// request queue and port sizing shared by the whole bank
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// Data and address widths
`define L2_XLEN        32
`define L2_ADDR_BITS   32
`define L2_BLK_BITS    128
`define L2_OFFSET_BITS 4

// Sets and ways, tag covers the address bits above index and offset
`define L2_NUM_SETS    16
`define L2_INDEX_BITS  4
`define L2_TAG_BITS    24
`define L2_NUM_WAY     2

// Requester side
`define L2_NUM_PORTS   2
`define L2_PORT_BITS   1
`define L2_QUEUE_DEPTH 4
`define L2_ID_BITS     4

`endif

// ==== src/l2_pkg.sv ====
// L2 bank types
// Request and response structs seen by the L1 ports, the block
// level memory structs, and the entry held in the request queue
`include "l2_defs.svh"

package l2_pkg;

  // ========================================
  // L1 side
  // ========================================

  // One request from an L1, write stores a single word
  typedef struct packed {
    logic                      valid;
    // 1 means write
    logic                      rw;
    logic [`L2_ADDR_BITS-1:0]  addr;
    logic [`L2_XLEN-1:0]       wdata;
    logic [`L2_ID_BITS-1:0]    id;
  } l2_req_t;

  // Response to an L1, ready is the request handshake of that port
  typedef struct packed {
    logic                      valid;
    logic                      ready;
    logic [`L2_BLK_BITS-1:0]   blk;
    logic [`L2_ID_BITS-1:0]    id;
  } l2_res_t;

  // ========================================
  // Memory side
  // ========================================

  // Block request to memory, rw=1 is a posted write-back
  typedef struct packed {
    logic                      valid;
    logic                      rw;
    // Always block aligned
    logic [`L2_ADDR_BITS-1:0]  addr;
    logic [`L2_BLK_BITS-1:0]   blk;
  } mem_req_t;

  // Read data returned by memory
  typedef struct packed {
    logic                      valid;
    logic [`L2_BLK_BITS-1:0]   blk;
  } mem_res_t;

  // ========================================
  // Queue entry
  // ========================================

  // Request plus the port it came in on, used to route the response
  typedef struct packed {
    l2_req_t                   req;
    logic [`L2_PORT_BITS-1:0]  port;
  } queue_entry_t;

endpackage

// ==== src/l2_req_queue.sv ====
// L2 request queue
// Circular buffer with one write lane per L1 port and a single read
// lane toward the cache core. Port 0 is written ahead of port 1 in
// the same cycle. The head is popped as a one-cycle issue strobe
// whenever the core reports idle.
`include "l2_defs.svh"

module l2_req_queue
  import l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  l2_req_t [`L2_NUM_PORTS-1:0]  req_i,
  input  logic                         core_idle_i,
  output logic [`L2_NUM_PORTS-1:0]     port_ready_o,
  output queue_entry_t                 issue_o
);

  localparam int PTR_BITS = $clog2(`L2_QUEUE_DEPTH);
  localparam int CNT_BITS = PTR_BITS + 1;

  // Entry storage
  queue_entry_t              fifo_mem [`L2_QUEUE_DEPTH];

  // Pointers and occupancy
  logic [PTR_BITS-1:0]       head_q;
  logic [PTR_BITS-1:0]       tail_q;
  logic [CNT_BITS-1:0]       count_q;

  // Per-cycle write side
  logic                      ready_all;
  logic [`L2_NUM_PORTS-1:0]  accept;
  logic [PTR_BITS-1:0]       wr_ptr [`L2_NUM_PORTS];
  logic [CNT_BITS-1:0]       push_cnt;

  // Read side
  logic                      pop;
  logic                      issue_valid_q;
  queue_entry_t              issue_ent_q;

  // ========================================
  // Write side
  // ========================================

  // Ready needs room for one write per port in the registered count
  assign ready_all = (CNT_BITS'(`L2_QUEUE_DEPTH) - count_q) >= CNT_BITS'(`L2_NUM_PORTS);

  // All ports share one ready
  assign port_ready_o = {`L2_NUM_PORTS{ready_all}};

  // Lower ports take the earlier slots
  always_comb begin
    push_cnt = '0;
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      accept[p] = req_i[p].valid && ready_all;
      wr_ptr[p] = tail_q + PTR_BITS'(push_cnt);
      if (accept[p]) begin
        push_cnt = push_cnt + 1'b1;
      end
    end
  end

  // ========================================
  // Read side
  // ========================================

  // No pop while a strobe is out because the core drops idle a cycle later
  assign pop = (count_q != '0) && core_idle_i && !issue_valid_q;

  // Entry and issue payload
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      if (accept[p]) begin
        fifo_mem[wr_ptr[p]] <= '{req: req_i[p], port: `L2_PORT_BITS'(p)};
      end
    end
    if (pop) begin
      issue_ent_q <= fifo_mem[head_q];
    end
  end

  // Pointers, count and strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      issue_valid_q <= 1'b0;
    end else begin
      tail_q  <= tail_q + PTR_BITS'(push_cnt);
      count_q <= count_q + push_cnt - CNT_BITS'(pop);
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      issue_valid_q <= pop;
    end
  end

  // Strobe valid overrides whatever valid was stored with the entry
  always_comb begin
    issue_o           = issue_ent_q;
    issue_o.req.valid = issue_valid_q;
  end

  // ========================================
  // Checks
  // ========================================

  // Ready threshold must keep the buffer from overflowing
  a_count_bound: assert property (
    @(posedge clk_i) disable iff (rst_i)
      count_q <= CNT_BITS'(`L2_QUEUE_DEPTH)
  ) else $error("request queue count over depth");

  // Head and tail must still show an entry whenever the head is popped
  a_pop_nonempty: assert property (
    @(posedge clk_i) disable iff (rst_i)
      pop |-> ((head_q != tail_q) || (count_q == CNT_BITS'(`L2_QUEUE_DEPTH)))
  ) else $error("request queue popped while empty");

endmodule

// ==== src/l2_cache_core.sv ====
// L2 cache core
// Single-ported 2-way set-associative cache, 16 sets of 16-byte blocks,
// one LRU bit per set, write-back and write-allocate. Serves one queue
// entry at a time: lookup, optional dirty write-back, block refill,
// then the response strobe on the port that issued the request.
`include "l2_defs.svh"

module l2_cache_core
  import l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  queue_entry_t                 issue_i,
  output logic                         core_idle_o,
  output l2_res_t [`L2_NUM_PORTS-1:0]  res_o,
  output mem_req_t                     mem_req_o,
  input  mem_res_t                     mem_res_i
);

  localparam int WORDS     = `L2_BLK_BITS / `L2_XLEN;
  localparam int WSEL_BITS = $clog2(WORDS);
  localparam int WAY_BITS  = $clog2(`L2_NUM_WAY);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL_WAIT,
    ST_REFILL,
    ST_RESPOND
  } state_e;

  state_e                     state_q;

  // ========================================
  // Storage
  // ========================================
  logic [`L2_TAG_BITS-1:0]    tag_arr   [`L2_NUM_WAY][`L2_NUM_SETS];
  logic [`L2_BLK_BITS-1:0]    data_arr  [`L2_NUM_WAY][`L2_NUM_SETS];
  logic [`L2_NUM_SETS-1:0]    valid_arr [`L2_NUM_WAY];
  logic [`L2_NUM_SETS-1:0]    dirty_arr [`L2_NUM_WAY];
  // Way to evict next, per set
  logic [`L2_NUM_SETS-1:0]    lru_q;

  // Request being served and its miss context
  queue_entry_t               ent_q;
  logic [WAY_BITS-1:0]        vict_q;
  logic [`L2_BLK_BITS-1:0]    refill_blk_q;
  logic [`L2_BLK_BITS-1:0]    res_blk_q;

  // Memory strobe, only the valid bit is control state
  logic                       mem_valid_q;
  logic                       mem_rw_q;
  logic [`L2_ADDR_BITS-1:0]   mem_addr_q;
  logic [`L2_BLK_BITS-1:0]    mem_blk_q;

  // Address decode of the current request
  logic [`L2_INDEX_BITS-1:0]  idx;
  logic [`L2_TAG_BITS-1:0]    tag;
  logic [WSEL_BITS-1:0]       wsel;
  logic [`L2_ADDR_BITS-1:0]   blk_addr;

  // Lookup results
  logic                       hit;
  logic [WAY_BITS-1:0]        hit_way;
  logic [`L2_BLK_BITS-1:0]    merged_blk;
  logic [WAY_BITS-1:0]        vict_way;
  logic                       vict_dirty;
  logic [`L2_ADDR_BITS-1:0]   wb_addr;

  assign idx      = ent_q.req.addr[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
  assign tag      = ent_q.req.addr[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
  assign wsel     = ent_q.req.addr[`L2_OFFSET_BITS-1 -: WSEL_BITS];
  assign blk_addr = {ent_q.req.addr[`L2_ADDR_BITS-1:`L2_OFFSET_BITS],
                     {`L2_OFFSET_BITS{1'b0}}};

  // ========================================
  // Lookup
  // ========================================

  // Tag compare across ways
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `L2_NUM_WAY; w++) begin
      if (valid_arr[w][idx] && (tag_arr[w][idx] == tag)) begin
        hit     = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
  end

  // Hit block with the write word dropped in, word 0 in the low bits
  always_comb begin
    merged_blk = data_arr[hit_way][idx];
    if (ent_q.req.rw) begin
      merged_blk[wsel*`L2_XLEN +: `L2_XLEN] = ent_q.req.wdata;
    end
  end

  // Victim is always the LRU way
  assign vict_way   = lru_q[idx];
  assign vict_dirty = valid_arr[vict_way][idx] && dirty_arr[vict_way][idx];
  assign wb_addr    = {tag_arr[vict_way][idx], idx, {`L2_OFFSET_BITS{1'b0}}};

  // ========================================
  // Control FSM
  // ========================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      mem_valid_q <= 1'b0;
      lru_q       <= '0;
      for (int w = 0; w < `L2_NUM_WAY; w++) begin
        valid_arr[w] <= '0;
        dirty_arr[w] <= '0;
      end
    end else begin
      // Memory strobe lasts one cycle
      mem_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (issue_i.req.valid) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            // Other way becomes the next victim
            lru_q[idx] <= ~hit_way;
            if (ent_q.req.rw) begin
              dirty_arr[hit_way][idx] <= 1'b1;
            end
            state_q <= ST_RESPOND;
          end else begin
            // Write-back or read strobe goes out next cycle
            mem_valid_q <= 1'b1;
            state_q     <= vict_dirty ? ST_WRITEBACK : ST_REFILL_WAIT;
          end
        end
        ST_WRITEBACK: begin
          // Read strobe right after the posted write-back
          mem_valid_q <= 1'b1;
          state_q     <= ST_REFILL_WAIT;
        end
        ST_REFILL_WAIT: begin
          if (mem_res_i.valid) begin
            state_q <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          valid_arr[vict_q][idx] <= 1'b1;
          dirty_arr[vict_q][idx] <= 1'b0;
          // Replay the lookup, it hits now
          state_q <= ST_LOOKUP;
        end
        ST_RESPOND: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // ========================================
  // Datapath
  // ========================================
  always_ff @(posedge clk_i) begin
    case (state_q)
      ST_IDLE: begin
        if (issue_i.req.valid) begin
          ent_q <= issue_i;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          data_arr[hit_way][idx] <= merged_blk;
          res_blk_q              <= merged_blk;
        end else begin
          vict_q     <= vict_way;
          mem_rw_q   <= vict_dirty;
          mem_addr_q <= vict_dirty ? wb_addr : blk_addr;
          mem_blk_q  <= vict_dirty ? data_arr[vict_way][idx] : '0;
        end
      end
      ST_WRITEBACK: begin
        mem_rw_q   <= 1'b0;
        mem_addr_q <= blk_addr;
        mem_blk_q  <= '0;
      end
      ST_REFILL_WAIT: begin
        if (mem_res_i.valid) begin
          refill_blk_q <= mem_res_i.blk;
        end
      end
      ST_REFILL: begin
        data_arr[vict_q][idx] <= refill_blk_q;
        tag_arr[vict_q][idx]  <= tag;
      end
      default: begin
      end
    endcase
  end

  // ========================================
  // Outputs
  // ========================================
  assign core_idle_o = (state_q == ST_IDLE);

  assign mem_req_o = '{valid: mem_valid_q, rw: mem_rw_q, addr: mem_addr_q, blk: mem_blk_q};

  // Response only on the port named by the entry tag, ready left low here
  always_comb begin
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      res_o[p] = '0;
      if ((state_q == ST_RESPOND) && (ent_q.port == `L2_PORT_BITS'(p))) begin
        res_o[p].valid = 1'b1;
        res_o[p].blk   = res_blk_q;
        res_o[p].id    = ent_q.req.id;
      end
    end
  end

  // Queue must hold off while a request is in flight
  a_issue_when_idle: assert property (
    @(posedge clk_i) disable iff (rst_i)
      issue_i.req.valid |-> (state_q == ST_IDLE)
  ) else $error("issue strobe while cache core busy");

  // Memory only answers the single outstanding block read
  a_mem_res_in_wait: assert property (
    @(posedge clk_i) disable iff (rst_i)
      mem_res_i.valid |-> (state_q == ST_REFILL_WAIT)
  ) else $error("memory response outside refill wait");

endmodule

// ==== src/l2_bank_multiport.sv ====
// Two-port L2 cache bank
// Request queue in front of one cache core. Port 0 serves the
// instruction L1, port 1 the data L1. The queue's per-port ready is
// folded into each response struct on the way out.
`include "l2_defs.svh"

module l2_bank_multiport
  import l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  l2_req_t [`L2_NUM_PORTS-1:0]  req_i,
  output l2_res_t [`L2_NUM_PORTS-1:0]  res_o,
  output mem_req_t                     mem_req_o,
  input  mem_res_t                     mem_res_i
);

  // Queue to core
  logic [`L2_NUM_PORTS-1:0]     port_ready;
  logic                         core_idle;
  queue_entry_t                 issue;

  // Core responses before ready is merged
  l2_res_t [`L2_NUM_PORTS-1:0]  core_res;

  // ========================================
  // Request queue
  // ========================================
  l2_req_queue l2_req_queue_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .core_idle_i  (core_idle),
    .port_ready_o (port_ready),
    .issue_o      (issue)
  );

  // ========================================
  // Cache core
  // ========================================
  l2_cache_core l2_cache_core_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue_i     (issue),
    .core_idle_o (core_idle),
    .res_o       (core_res),
    .mem_req_o   (mem_req_o),
    .mem_res_i   (mem_res_i)
  );

  // Each port's ready comes straight from the queue
  for (genvar p = 0; p < `L2_NUM_PORTS; p++) begin : g_port_ready
    assign res_o[p] = '{valid: core_res[p].valid,
                        ready: port_ready[p],
                        blk:   core_res[p].blk,
                        id:    core_res[p].id};
  end

endmodule

// ==== verif/tb_mem_model.sv ====
// Behavioral block memory for the L2 bank testbench
// Answers each block read a fixed number of cycles after its strobe
// and keeps posted write-backs, which override the fill pattern
`include "l2_defs.svh"

module tb_mem_model
  import l2_pkg::*;
#(
  parameter logic [31:0] PATTERN      = 32'h0,
  parameter int          READ_LATENCY = 4
) (
  input  logic     clk_i,
  input  mem_req_t mem_req_i,
  output mem_res_t mem_res_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS = `L2_BLK_BITS / `L2_XLEN;

  // Written-back blocks, keyed by block address
  logic [`L2_BLK_BITS-1:0]  wb_mem [logic [`L2_ADDR_BITS-1:0]];

  // Only one read is ever outstanding
  logic                     pend      = 1'b0;
  int                       wait_cnt  = 0;
  logic [`L2_ADDR_BITS-1:0] pend_addr = '0;
  mem_res_t                 res_q     = '0;

  // Unwritten word w of block a holds (a + 4w) xor pattern
  function automatic logic [`L2_BLK_BITS-1:0] read_blk(input logic [`L2_ADDR_BITS-1:0] a);
    logic [`L2_BLK_BITS-1:0] b;
    if (wb_mem.exists(a)) begin
      b = wb_mem[a];
    end else begin
      for (int w = 0; w < WORDS; w++) begin
        b[w*`L2_XLEN +: `L2_XLEN] = (a + 32'(4 * w)) ^ PATTERN;
      end
    end
    return b;
  endfunction

  // ========================================
  // Request handling, on the falling edge
  // ========================================
  always @(negedge clk_i) begin
    mem_res_t nxt;
    nxt = '0;
    // Count down the pending read
    if (pend) begin
      if (wait_cnt == 1) begin
        nxt.valid = 1'b1;
        nxt.blk   = read_blk(pend_addr);
        pend      = 1'b0;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
    if (mem_req_i.valid === 1'b1) begin
      if (mem_req_i.rw) begin
        // Posted, no answer
        wb_mem[mem_req_i.addr] = mem_req_i.blk;
      end else begin
        pend      = 1'b1;
        wait_cnt  = READ_LATENCY;
        pend_addr = mem_req_i.addr;
      end
    end
    res_q = nxt;
  end

  assign mem_res_o = res_q;

endmodule

// ==== verif/tb_l2_bank.sv ====
// Testbench for the two-port L2 cache bank
// Directed tests drive both L1 ports, a behavioral memory serves the
// block reads, and a scoreboard checks every response against the
// testbench's own reference view of memory
`include "l2_defs.svh"

module tb_l2_bank
  import l2_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] MEM_PATTERN = 32'hA5A50000;
  // Six tests of at most 400 cycles, with margin
  localparam int          MAX_CYCLES  = 3000;
  localparam int          HIT_LATENCY = 3;

  // One expected response, in acceptance order
  typedef struct packed {
    logic [`L2_PORT_BITS-1:0] port;
    logic [31:0]              acc_cyc;
    l2_res_t                  res;
  } expect_t;

  logic                         clk;
  logic                         rst;
  l2_req_t [`L2_NUM_PORTS-1:0]  req;
  l2_res_t [`L2_NUM_PORTS-1:0]  res;
  mem_req_t                     mem_req;
  mem_res_t                     mem_res;

  logic [31:0]  cyc = '0;
  logic [31:0]  rng_state;
  logic [31:0]  last_lat;
  logic         saw_ready_low;

  // Scoreboard and memory strobe log
  expect_t      exp_q [$];
  mem_req_t     mem_q [$];
  logic [31:0]  mem_cyc_q [$];
  // Coherent view of memory where unlisted blocks hold the pattern
  logic [`L2_BLK_BITS-1:0] ref_mem [logic [31:0]];

  // Request held per port until ready takes it
  l2_req_t      slot [`L2_NUM_PORTS];
  logic         slot_full [`L2_NUM_PORTS];

  l2_bank_multiport l2_bank_multiport_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .req_i     (req),
    .res_o     (res),
    .mem_req_o (mem_req),
    .mem_res_i (mem_res)
  );

  tb_mem_model #(
    .PATTERN      (MEM_PATTERN),
    .READ_LATENCY (4)
  ) tb_mem_model_inst (
    .clk_i     (clk),
    .mem_req_i (mem_req),
    .mem_res_o (mem_res)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      fail_now("timeout: the run went past its cycle limit");
    end
  end

  // ========================================
  // Helpers
  // ========================================
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at cycle %0d", cyc);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] block_of(input logic [31:0] a);
    return {a[31:4], 4'h0};
  endfunction

  // Random tag and word, fixed set
  function automatic logic [31:0] addr_in_set(input logic [3:0] set_idx);
    logic [31:0] r;
    r = rand_word();
    return {r[31:8], set_idx, r[3:2], 2'b00};
  endfunction

  function automatic logic [`L2_BLK_BITS-1:0] ref_block(input logic [31:0] a);
    logic [31:0]             ba;
    logic [`L2_BLK_BITS-1:0] b;
    ba = block_of(a);
    if (ref_mem.exists(ba)) begin
      b = ref_mem[ba];
    end else begin
      for (int w = 0; w < 4; w++) begin
        b[w*32 +: 32] = (ba + 32'(4 * w)) ^ MEM_PATTERN;
      end
    end
    return b;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_res(input string name, input l2_res_t got, input l2_res_t exp);
    if (got.valid !== exp.valid || got.blk !== exp.blk || got.id !== exp.id) begin
      fail_now($sformatf("[FAIL] %s got valid=%h blk=%h id=%h, expected valid=%h blk=%h id=%h",
                         name, got.valid, got.blk, got.id, exp.valid, exp.blk, exp.id));
    end
  endtask

  // Read strobes carry no data worth checking
  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got.valid !== exp.valid || got.rw !== exp.rw || got.addr !== exp.addr ||
        (exp.rw && got.blk !== exp.blk)) begin
      fail_now($sformatf("[FAIL] %s got rw=%h addr=%h blk=%h, expected rw=%h addr=%h blk=%h",
                         name, got.rw, got.addr, got.blk, exp.rw, exp.addr, exp.blk));
    end
  endtask

  task automatic check_ready(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %s got %h, expected %h", name, got, exp));
    end
  endtask

  // ========================================
  // Driving and scoreboard
  // ========================================

  // Update the reference and queue the response this request must get
  task automatic record_accept(input int p, input l2_req_t r);
    logic [`L2_BLK_BITS-1:0] b;
    expect_t                 e;
    int                      wsel;
    b    = ref_block(r.addr);
    wsel = int'(r.addr[3:2]);
    if (r.rw) begin
      b[wsel*32 +: 32] = r.wdata;
      ref_mem[block_of(r.addr)] = b;
    end
    e.port    = `L2_PORT_BITS'(p);
    e.acc_cyc = cyc + 1;
    e.res     = '{valid: 1'b1, ready: 1'b0, blk: b, id: r.id};
    exp_q.push_back(e);
  endtask

  task automatic observe_outputs();
    expect_t e;
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      if (res[p].valid) begin
        if (exp_q.size() == 0) begin
          fail_now($sformatf("response on port %0d with no request outstanding", p));
        end else begin
          e = exp_q.pop_front();
          if (e.port != `L2_PORT_BITS'(p)) begin
            fail_now($sformatf("response came back on port %0d, expected port %0d", p, e.port));
          end
          check_res($sformatf("res_o[%0d]", p), res[p], e.res);
          last_lat = cyc - e.acc_cyc;
        end
      end
    end
    if (mem_req.valid) begin
      mem_q.push_back(mem_req);
      mem_cyc_q.push_back(cyc);
    end
  endtask

  // One cycle sampled at the falling edge before the ports are driven
  task automatic step();
    int outstanding;
    @(negedge clk);
    observe_outputs();
    // Queue holds every unanswered request but at most one in the core
    outstanding = exp_q.size();
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      if (outstanding <= `L2_QUEUE_DEPTH - `L2_NUM_PORTS) begin
        check_ready($sformatf("res_o[%0d].ready", p), res[p].ready, 1'b1);
      end else if (outstanding >= `L2_QUEUE_DEPTH - `L2_NUM_PORTS + 2) begin
        check_ready($sformatf("res_o[%0d].ready", p), res[p].ready, 1'b0);
      end
    end
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      if (slot_full[p]) begin
        req[p]       = slot[p];
        req[p].valid = 1'b1;
        // Ready is registered, so it holds through the next rising edge
        if (res[p].ready) begin
          record_accept(p, slot[p]);
          slot_full[p] = 1'b0;
        end else begin
          saw_ready_low = 1'b1;
        end
      end else begin
        req[p] = '0;
      end
    end
  endtask

  task automatic offer(input int p, input logic rw, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] id);
    slot[p]      = '{valid: 1'b1, rw: rw, addr: addr, wdata: wdata, id: id};
    slot_full[p] = 1'b1;
  endtask

  // Run until every request is taken and answered, then watch for strays
  task automatic drain();
    while (slot_full[0] || slot_full[1] || exp_q.size() != 0) begin
      step();
    end
    repeat (4) step();
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic test_reset_state();
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      check_ready($sformatf("res_o[%0d].ready", p), res[p].ready, 1'b1);
    end
    repeat (10) step();
    if (mem_q.size() != 0) begin
      fail_now("memory strobe seen while the bank sat idle after reset");
    end
  endtask

  task automatic test_read_miss_then_hit();
    logic [31:0] a;
    a = addr_in_set(4'd3);
    offer(1, 1'b0, a, '0, 4'h5);
    drain();
    if (mem_q.size() != 1) begin
      fail_now($sformatf("read miss gave %0d memory strobes instead of one", mem_q.size()));
    end
    check_mem_req("mem_req_o", mem_q.pop_front(),
                  '{valid: 1'b1, rw: 1'b0, addr: block_of(a), blk: '0});
    mem_cyc_q.delete();
    // Same block again is a hit
    offer(1, 1'b0, a, '0, 4'h6);
    drain();
    if (last_lat != HIT_LATENCY) begin
      fail_now($sformatf("hit answered %0d cycles after acceptance", last_lat));
    end
    if (mem_q.size() != 0) begin
      fail_now("read hit went out to memory");
    end
  endtask

  task automatic test_dual_issue();
    offer(0, 1'b0, addr_in_set(4'd6), '0, 4'h1);
    offer(1, 1'b1, addr_in_set(4'd7), rand_word(), 4'h2);
    step();
    if (slot_full[0] || slot_full[1]) begin
      fail_now("both ports offered in one cycle but not both were taken");
    end
    drain();
  endtask

  // Reference replaces one word of the old block
  task automatic test_write_merge();
    logic [31:0] a;
    a = addr_in_set(4'd5);
    offer(1, 1'b1, a, rand_word(), 4'h3);
    drain();
    offer(0, 1'b0, a, '0, 4'h4);
    drain();
  endtask

  task automatic test_dirty_eviction();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = addr_in_set(4'd9);
    b = a ^ 32'h100;
    c = a ^ 32'h200;
    offer(1, 1'b1, a, rand_word(), 4'h7);
    drain();
    offer(1, 1'b0, b, '0, 4'h8);
    drain();
    mem_q.delete();
    mem_cyc_q.delete();
    // Set is full, A is LRU and dirty
    offer(0, 1'b0, c, '0, 4'h9);
    drain();
    if (mem_q.size() != 2) begin
      fail_now($sformatf("eviction gave %0d memory strobes instead of two", mem_q.size()));
    end
    check_mem_req("mem_req_o", mem_q[0],
                  '{valid: 1'b1, rw: 1'b1, addr: block_of(a), blk: ref_block(a)});
    check_mem_req("mem_req_o", mem_q[1],
                  '{valid: 1'b1, rw: 1'b0, addr: block_of(c), blk: '0});
    if (mem_cyc_q[1] != mem_cyc_q[0] + 1) begin
      fail_now("read strobe did not follow the write-back in the next cycle");
    end
    // A now comes back from the stored write-back
    offer(1, 1'b0, a, '0, 4'hA);
    drain();
  endtask

  task automatic test_back_pressure();
    int          sent [`L2_NUM_PORTS];
    logic [31:0] base;
    logic [31:0] r;
    saw_ready_low = 1'b0;
    base = addr_in_set(4'd11);
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      sent[p] = 0;
    end
    while (sent[0] < 10 || sent[1] < 10) begin
      for (int p = 0; p < `L2_NUM_PORTS; p++) begin
        if (!slot_full[p] && sent[p] < 10) begin
          // Four blocks fight over one set, port 1 also writes
          r = rand_word();
          offer(p, (p == 1) && r[4], {base[31:10], r[9:8], base[7:4], r[3:2], 2'b00},
                rand_word(), 4'(sent[p]));
          sent[p] = sent[p] + 1;
        end
      end
      step();
    end
    drain();
    if (!saw_ready_low) begin
      fail_now("ready never dropped while both ports kept offering");
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    rng_state     = 32'h71c9;
    last_lat      = '0;
    saw_ready_low = 1'b0;
    req           = '0;
    for (int p = 0; p < `L2_NUM_PORTS; p++) begin
      slot[p]      = '0;
      slot_full[p] = 1'b0;
    end
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_read_miss_then_hit();
    test_dual_issue();
    test_write_merge();
    test_dirty_eviction();
    test_back_pressure();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
src/l2_pkg.sv
src/l2_req_queue.sv
src/l2_cache_core.sv
src/l2_bank_multiport.sv
verif/tb_mem_model.sv
verif/tb_l2_bank.sv

// ==== run.sh ====
#!/bin/sh
# Build the L2 bank testbench with Verilator, run it, and judge sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_l2_bank -f all.f -o Vtb_l2_bank &&
  ./obj_dir/Vtb_l2_bank > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
